//--- files.f
logic/mipsPkg.sv
logic/registerFile.sv
logic/aluUnit.sv
logic/cpuControl.sv
logic/mipsCpuBus.sv
verification/clockGen.sv
verification/avalonMemory.sv
verification/mipsCpuBusTb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f files.f --top-module mipsCpuBusTb -o simv

run: compile
	./obj_dir/simv | tee sim.log
	grep -q "^TEST OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verification/mipsCpuBusTb.sv
`timescale 1ns/1ps

module mipsCpuBusTb;
    import mipsPkg::*;

    typedef struct {
        bit          isR;
        opcodeT      op;
        functT       fn;
        logic [31:0] a;
        logic [31:0] b;
        logic [15:0] imm;
        bit          zeroDest;
    } rowT;

    logic clk, reset, resetRequest, active, write, read, waitrequest;
    logic [31:0] registerV0, address, writedata, readdata;
    logic [3:0]  byteenable;
    rowT         rows[$];
    logic [31:0] prog[$];
    int          errors, checks, timeouts;

    clockGen clock0 (.resetRequest(resetRequest), .clk(clk), .reset(reset));

    avalonMemory memory0 (
        .clk(clk), .address(address), .read(read), .write(write),
        .writedata(writedata), .readdata(readdata), .waitrequest(waitrequest)
    );

    mipsCpuBus dut0 (
        .clk(clk), .reset(reset), .active(active), .register_v0(registerV0),
        .address(address), .write(write), .read(read), .waitrequest(waitrequest),
        .writedata(writedata), .byteenable(byteenable), .readdata(readdata)
    );

    function automatic logic [31:0] rType(functT fn, logic [4:0] rs, logic [4:0] rt,
                                          logic [4:0] rd, logic [4:0] sh);
        return {6'd0, rs, rt, rd, sh, fn};
    endfunction

    function automatic logic [31:0] iType(opcodeT op, logic [4:0] rs, logic [4:0] rt,
                                          logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Expected v0 from the MIPS-I instruction rules
    function automatic logic [31:0] expectedV0(rowT r);
        logic [31:0] sImm;
        logic [31:0] zImm;
        sImm = {{16{r.imm[15]}}, r.imm};
        zImm = {16'h0000, r.imm};
        if (r.isR) begin
            if (r.zeroDest) return r.b;
            case (r.fn)
                ADDU: return r.a + r.b;
                SUBU: return r.a - r.b;
                AND:  return r.a & r.b;
                OR:   return r.a | r.b;
                XOR:  return r.a ^ r.b;
                SLT:  return ($signed(r.a) < $signed(r.b)) ? 32'd1 : 32'd0;
                SLTU: return (r.a < r.b) ? 32'd1 : 32'd0;
                SLL:  return r.b << r.imm[4:0];
                SRL:  return r.b >> r.imm[4:0];
                SRA:  return $unsigned($signed(r.b) >>> r.imm[4:0]);
                SLLV: return r.b << r.a[4:0];
                SRLV: return r.b >> r.a[4:0];
                SRAV: return $unsigned($signed(r.b) >>> r.a[4:0]);
                default: return 32'd0;
            endcase
        end
        case (r.op)
            ADDIU: return r.a + sImm;
            SLTI:  return ($signed(r.a) < $signed(sImm)) ? 32'd1 : 32'd0;
            SLTIU: return (r.a < sImm) ? 32'd1 : 32'd0;
            ANDI:  return r.a & zImm;
            ORI:   return r.a | zImm;
            XORI:  return r.a ^ zImm;
            LUI:   return {r.imm, 16'h0000};
            SW:    return r.a;
            // Delay slot gives 1, skipped slot adds 2, target adds 4
            BEQ:   return (r.a == r.b) ? 32'd5 : 32'd7;
            BNE:   return (r.a != r.b) ? 32'd5 : 32'd7;
            JAL:   return defaultResetVector + 32'h18;
            default: return 32'd0;
        endcase
    endfunction

    task automatic addRow(bit isR, opcodeT op, functT fn, logic [31:0] a, logic [31:0] b,
                          logic [15:0] imm, bit zeroDest);
        rows.push_back('{isR, op, fn, a, b, imm, zeroDest});
    endtask

    task automatic compareValue(string what, logic [31:0] got, logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns %s: got %h, expected %h", $time, what, got, exp);
        end
    endtask

    // Operands into r8 and r9, result into r2, then jump to 0
    task automatic buildProgram(rowT r);
        prog.delete();
        prog.push_back(iType(LUI, 5'd0, 5'd8, r.a[31:16]));
        prog.push_back(iType(ORI, 5'd8, 5'd8, r.a[15:0]));
        prog.push_back(iType(LUI, 5'd0, 5'd9, r.b[31:16]));
        prog.push_back(iType(ORI, 5'd9, 5'd9, r.b[15:0]));
        if (r.isR) begin
            prog.push_back(rType(r.fn, 5'd8, 5'd9, r.zeroDest ? 5'd0 : 5'd2, r.imm[4:0]));
            if (r.zeroDest) prog.push_back(rType(ADDU, 5'd0, 5'd9, 5'd2, 5'd0));
        end else if (r.op == SW) begin
            prog.push_back(iType(SW, 5'd9, 5'd8, r.imm));
            prog.push_back(iType(LW, 5'd9, 5'd2, r.imm));
        end else if (r.op == BEQ || r.op == BNE) begin
            prog.push_back(iType(r.op, 5'd8, 5'd9, 16'd2));
            prog.push_back(iType(ADDIU, 5'd0, 5'd2, 16'd1));
            prog.push_back(iType(ADDIU, 5'd2, 5'd2, 16'd2));
            prog.push_back(iType(ADDIU, 5'd2, 5'd2, 16'd4));
        end else if (r.op == JAL) begin
            // Subroutine at word 10 returns through r31 to word 6
            prog.push_back({JAL, 26'(((defaultResetVector + 32'h28) >> 2))});
            prog.push_back(32'd0);
            prog.push_back(rType(ADDU, 5'd31, 5'd0, 5'd2, 5'd0));
            prog.push_back(rType(JR, 5'd0, 5'd0, 5'd0, 5'd0));
            prog.push_back(32'd0);
            prog.push_back(32'd0);
            prog.push_back(rType(JR, 5'd31, 5'd0, 5'd0, 5'd0));
            prog.push_back(32'd0);
        end else begin
            prog.push_back(iType(r.op, 5'd8, 5'd2, r.imm));
        end
        prog.push_back(rType(JR, 5'd0, 5'd0, 5'd0, 5'd0));
        prog.push_back(32'd0);
        for (int i = 0; i < 1024; i++) memory0.mem[i[9:0]] = 32'h5A5A_0000 ^ (i << 2);
        for (int i = 0; i < prog.size(); i++) memory0.mem[i[9:0]] = prog[i];
    endtask

    task automatic resetCore(output bit ok);
        int n;
        n = 0;
        @(posedge clk);
        #1 resetRequest = 1'b1;
        @(posedge clk);
        #1 resetRequest = 1'b0;
        // First edge on which the core sees reset
        @(posedge clk);
        do begin
            @(negedge clk);
            n++;
            compareValue("active in reset", {31'd0, active}, 32'd1);
            compareValue("read/write in reset", {30'd0, read, write}, 32'd0);
        end while (reset && n < 20);
        ok = !reset;
    endtask

    task automatic waitHalt(output bit ok);
        int n;
        n = 0;
        while (active && n < 3000) begin
            @(negedge clk);
            n++;
            // Every bus access is a full word
            if (read || write) begin
                compareValue("byteenable on bus access", {28'd0, byteenable}, 32'h0000_000F);
            end
        end
        ok = !active;
    endtask

    initial begin
        bit ok;
        rowT r;
        void'($urandom(22336));
        resetRequest = 1'b0;
        addRow(1'b1, SPECIAL, ADDU, 32'h7FFF_FFFF, 32'h0000_0001, 16'h0, 1'b0);
        addRow(1'b1, SPECIAL, SUBU, 32'h0000_0005, 32'h0000_0009, 16'h0, 1'b0);
        addRow(1'b1, SPECIAL, AND,  32'hF0F0_1234, 32'h0FF0_FF00, 16'h0, 1'b0);
        addRow(1'b1, SPECIAL, OR,   32'hF0F0_1234, 32'h0FF0_FF00, 16'h0, 1'b0);
        addRow(1'b1, SPECIAL, XOR,  32'hF0F0_1234, 32'h0FF0_FF00, 16'h0, 1'b0);
        addRow(1'b1, SPECIAL, SLT,  32'hFFFF_FFF0, 32'h0000_0003, 16'h0, 1'b0);
        addRow(1'b1, SPECIAL, SLTU, 32'hFFFF_FFF0, 32'h0000_0003, 16'h0, 1'b0);
        addRow(1'b1, SPECIAL, SLL,  32'h0, 32'h8000_0001, 16'd4, 1'b0);
        addRow(1'b1, SPECIAL, SRL,  32'h0, 32'h8000_0001, 16'd31, 1'b0);
        addRow(1'b1, SPECIAL, SRA,  32'h0, 32'h8000_0000, 16'd4, 1'b0);
        addRow(1'b1, SPECIAL, SLLV, 32'd35, 32'h1234_5678, 16'h0, 1'b0);
        addRow(1'b1, SPECIAL, SRLV, 32'd8, 32'h8765_4321, 16'h0, 1'b0);
        addRow(1'b1, SPECIAL, SRAV, 32'd12, 32'h8765_4321, 16'h0, 1'b0);
        addRow(1'b1, SPECIAL, ADDU, 32'h1111_1111, 32'h2222_2222, 16'h0, 1'b1);
        addRow(1'b0, ADDIU, ADDU, 32'd10, 32'h0, 16'hFFFF, 1'b0);
        addRow(1'b0, SLTI,  ADDU, 32'hFFFF_FFFE, 32'h0, 16'hFFFF, 1'b0);
        addRow(1'b0, SLTIU, ADDU, 32'd5, 32'h0, 16'hFFFF, 1'b0);
        addRow(1'b0, ANDI,  ADDU, 32'hFFFF_FFFF, 32'h0, 16'h8F0F, 1'b0);
        addRow(1'b0, ORI,   ADDU, 32'h1234_0000, 32'h0, 16'h8001, 1'b0);
        addRow(1'b0, XORI,  ADDU, 32'hFFFF_FFFF, 32'h0, 16'hA5A5, 1'b0);
        addRow(1'b0, LUI,   ADDU, 32'h0, 32'h0, 16'hABCD, 1'b0);
        addRow(1'b0, SW,    ADDU, 32'hCAFE_BABE, 32'h0000_0100, 16'h0008, 1'b0);
        addRow(1'b0, BEQ,   ADDU, 32'd3, 32'd3, 16'h0, 1'b0);
        addRow(1'b0, BEQ,   ADDU, 32'd3, 32'd4, 16'h0, 1'b0);
        addRow(1'b0, BNE,   ADDU, 32'd3, 32'd4, 16'h0, 1'b0);
        addRow(1'b0, BNE,   ADDU, 32'd3, 32'd3, 16'h0, 1'b0);
        addRow(1'b0, JAL,   ADDU, 32'h0, 32'h0, 16'h0, 1'b0);

        foreach (rows[k]) begin
            r = rows[k];
            buildProgram(r);
            resetCore(ok);
            if (!ok) begin
                $display("Reset never released on row %0d", k);
                timeouts++;
                break;
            end
            waitHalt(ok);
            if (!ok) begin
                $display("Core did not halt on row %0d within 3000 cycles", k);
                timeouts++;
                break;
            end
            repeat (3) begin
                @(negedge clk);
                compareValue($sformatf("row %0d bus idle after halt", k),
                             {29'd0, active, read, write}, 32'd0);
            end
            compareValue($sformatf("row %0d register_v0", k), registerV0, expectedV0(r));
            if (!r.isR && r.op == SW) begin
                compareValue($sformatf("row %0d stored word", k),
                             memory0.mem[10'((r.b + {{16{r.imm[15]}}, r.imm}) >> 2)],
                             r.a);
            end
        end

        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- verification/avalonMemory.sv
`timescale 1ns/1ps

module avalonMemory (
    input  logic        clk,
    input  logic [31:0] address,
    input  logic        read,
    input  logic        write,
    input  logic [31:0] writedata,
    output logic [31:0] readdata,
    output logic        waitrequest
);
    // Word array, address bits 11:2
    logic [31:0] mem [1024];

    initial begin
        waitrequest = 1'b0;
    end

    assign readdata = mem[address[11:2]];

    always @(posedge clk) begin
        if (write && !waitrequest) begin
            mem[address[11:2]] <= writedata;
        end
    end

    // Stall about one cycle in three
    always @(posedge clk) begin
        #1;
        waitrequest <= ($urandom_range(2, 0) == 0);
    end

endmodule

//--- verification/clockGen.sv
`timescale 1ns/1ps

module clockGen (
    input  logic resetRequest,
    output logic clk,
    output logic reset
);
    int   cyclesLeft;
    logic requested;

    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        cyclesLeft = 5;
    end

    always #5 clk = ~clk;

    // Reset spans 5 rising edges, changes 1 ns after the edge
    always @(posedge clk) begin
        requested = resetRequest;
        #1;
        if (requested) begin
            reset      <= 1'b1;
            cyclesLeft <= 5;
        end else if (cyclesLeft > 1) begin
            cyclesLeft <= cyclesLeft - 1;
        end else begin
            reset      <= 1'b0;
            cyclesLeft <= 0;
        end
    end

endmodule

//--- logic/mipsCpuBus.sv
`timescale 1ns/1ps

module mipsCpuBus #(
    parameter logic [mipsPkg::dataWidth-1:0] resetVector = mipsPkg::defaultResetVector
) (
    input  logic                                clk,
    input  logic                                reset,
    output logic                                active,
    output logic [mipsPkg::dataWidth-1:0]       register_v0,
    output logic [mipsPkg::dataWidth-1:0]       address,
    output logic                                write,
    output logic                                read,
    input  logic                                waitrequest,
    output logic [mipsPkg::dataWidth-1:0]       writedata,
    output logic [mipsPkg::dataWidth/8-1:0]     byteenable,
    input  logic [mipsPkg::dataWidth-1:0]       readdata
);
    import mipsPkg::*;

    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [dataWidth-1:0]    rsValue;
    logic [dataWidth-1:0]    rtValue;
    logic                    writeEnable;
    logic [regAddrWidth-1:0] writeAddr;
    logic [dataWidth-1:0]    writeValue;
    logic [dataWidth-1:0]    instruction;
    logic [dataWidth-1:0]    result;
    logic                    branchTaken;

    // Word accesses only
    assign byteenable = '1;

    // Store data comes straight from the rt read port
    assign writedata = rtValue;

    cpuControl #(
        .resetVector(resetVector)
    ) control0 (
        .clk(clk),
        .reset(reset),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .result(result),
        .branchTaken(branchTaken),
        .rsValue(rsValue),
        .address(address),
        .read(read),
        .write(write),
        .rsAddr(rsAddr),
        .rtAddr(rtAddr),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeValue(writeValue),
        .instruction(instruction),
        .active(active)
    );

    registerFile regFile0 (
        .clk(clk),
        .reset(reset),
        .rsAddr(rsAddr),
        .rtAddr(rtAddr),
        .writeEnable(writeEnable),
        .writeAddr(writeAddr),
        .writeValue(writeValue),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .register_v0(register_v0)
    );

    aluUnit alu0 (
        .instruction(instruction),
        .rsValue(rsValue),
        .rtValue(rtValue),
        .result(result),
        .branchTaken(branchTaken)
    );

endmodule

//--- logic/cpuControl.sv
`timescale 1ns/1ps

module cpuControl #(
    parameter logic [mipsPkg::dataWidth-1:0] resetVector = mipsPkg::defaultResetVector
) (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               waitrequest,
    input  logic [mipsPkg::dataWidth-1:0]      readdata,
    input  logic [mipsPkg::dataWidth-1:0]      result,
    input  logic                               branchTaken,
    input  logic [mipsPkg::dataWidth-1:0]      rsValue,
    output logic [mipsPkg::dataWidth-1:0]      address,
    output logic                               read,
    output logic                               write,
    output logic [mipsPkg::regAddrWidth-1:0]   rsAddr,
    output logic [mipsPkg::regAddrWidth-1:0]   rtAddr,
    output logic                               writeEnable,
    output logic [mipsPkg::regAddrWidth-1:0]   writeAddr,
    output logic [mipsPkg::dataWidth-1:0]      writeValue,
    output logic [mipsPkg::dataWidth-1:0]      instruction,
    output logic                               active
);
    import mipsPkg::*;

    stateT                   state;
    logic [dataWidth-1:0]    pc;
    logic [dataWidth-1:0]    pendingTarget;
    logic                    pendingValid;
    logic [dataWidth-1:0]    resultReg;
    logic [dataWidth-1:0]    loadWord;

    opcodeT                  opcode;
    functT                   funct;
    logic [regAddrWidth-1:0] rdAddr;
    logic                    isSpecial;
    logic                    isLoad;
    logic                    isStore;
    logic                    isBranch;
    logic                    isJump;
    logic                    isLink;
    logic                    takeJump;
    logic                    finishing;
    logic [dataWidth-1:0]    pcPlus4;
    logic [dataWidth-1:0]    linkAddress;
    logic [dataWidth-1:0]    branchTarget;
    logic [dataWidth-1:0]    jumpTarget;
    logic [dataWidth-1:0]    nextPc;

    // Instruction fields
    assign opcode = opcodeT'(instruction[31:26]);
    assign funct  = functT'(instruction[5:0]);
    assign rsAddr = instruction[25:21];
    assign rtAddr = instruction[20:16];
    assign rdAddr = instruction[15:11];

    // Opcode classes
    assign isSpecial = (opcode == SPECIAL);
    assign isLoad    = (opcode == LW);
    assign isStore   = (opcode == SW);
    assign isBranch  = (opcode == BEQ) || (opcode == BNE);
    assign isJump    = (opcode == J) || (opcode == JAL)
                     || (isSpecial && ((funct == JR) || (funct == JALR)));
    assign isLink    = (opcode == JAL) || (isSpecial && (funct == JALR));

    assign pcPlus4      = pc + 32'd4;
    assign linkAddress  = pc + 32'd8;
    assign branchTarget = pcPlus4 + {{14{instruction[15]}}, instruction[15:0], 2'b00};

    always_comb begin
        if (isBranch) begin
            jumpTarget = branchTarget;
        end else if (isSpecial) begin
            jumpTarget = rsValue;
        end else begin
            jumpTarget = {pcPlus4[31:28], instruction[25:0], 2'b00};
        end
    end

    assign takeJump = (state == EXECUTE) && (isBranch || isJump) && branchTaken;

    // Last cycle of the current instruction
    assign finishing = ((state == EXECUTE) && (isBranch || isJump))
                     || ((state == MEMORY) && !waitrequest && isStore)
                     || (state == WRITEBACK);

    // A waiting target is taken once the delay slot has finished
    assign nextPc = pendingValid ? pendingTarget : pcPlus4;

    // Register write port
    assign writeEnable = (state == WRITEBACK) || ((state == EXECUTE) && isLink);

    always_comb begin
        if (opcode == JAL) begin
            writeAddr = 5'd31;
        end else if (isSpecial) begin
            writeAddr = rdAddr;
        end else begin
            writeAddr = rtAddr;
        end
    end

    always_comb begin
        if (isLink) begin
            writeValue = linkAddress;
        end else if (isLoad) begin
            writeValue = loadWord;
        end else begin
            writeValue = resultReg;
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if ((state == FETCH) && read && !waitrequest) begin
            instruction <= readdata;
        end
        if (state == EXECUTE) begin
            resultReg <= result;
        end
        if ((state == MEMORY) && read && !waitrequest) begin
            loadWord <= readdata;
        end
        if (takeJump) begin
            pendingTarget <= jumpTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= FETCH;
            pc           <= resetVector;
            address      <= resetVector;
            pendingValid <= 1'b0;
            read         <= 1'b0;
            write        <= 1'b0;
            active       <= 1'b1;
        end else begin
            case (state)
                FETCH: begin
                    // The first fetch after reset raises read one cycle late
                    if (!read) begin
                        read <= 1'b1;
                    end else if (!waitrequest) begin
                        read  <= 1'b0;
                        state <= DECODE;
                    end
                end
                DECODE: begin
                    state <= EXECUTE;
                end
                EXECUTE: begin
                    if (isLoad || isStore) begin
                        address <= result;
                        read    <= isLoad;
                        write   <= isStore;
                        state   <= MEMORY;
                    end else if (!(isBranch || isJump)) begin
                        state <= WRITEBACK;
                    end
                end
                MEMORY: begin
                    if (!waitrequest) begin
                        read  <= 1'b0;
                        write <= 1'b0;
                        if (isLoad) begin
                            state <= WRITEBACK;
                        end
                    end
                end
                HALTED: begin
                    active <= 1'b0;
                end
                default: begin
                end
            endcase

            if (finishing) begin
                pc           <= nextPc;
                pendingValid <= takeJump;
                // Fetching address zero ends the run
                if (nextPc == '0) begin
                    state <= HALTED;
                end else begin
                    state   <= FETCH;
                    address <= nextPc;
                    read    <= 1'b1;
                end
            end
        end
    end

endmodule

//--- logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
    input  logic [mipsPkg::dataWidth-1:0] instruction,
    input  logic [mipsPkg::dataWidth-1:0] rsValue,
    input  logic [mipsPkg::dataWidth-1:0] rtValue,
    output logic [mipsPkg::dataWidth-1:0] result,
    output logic                          branchTaken
);
    import mipsPkg::*;

    opcodeT               opcode;
    functT                funct;
    logic [4:0]           shamt;
    logic [4:0]           shiftVar;
    logic [15:0]          imm;
    logic [dataWidth-1:0] signImm;
    logic [dataWidth-1:0] zeroImm;

    assign opcode   = opcodeT'(instruction[31:26]);
    assign funct    = functT'(instruction[5:0]);
    assign shamt    = instruction[10:6];
    assign imm      = instruction[15:0];

    // Variable shifts use the low five bits of rs
    assign shiftVar = rsValue[4:0];

    // Immediate extensions
    assign signImm = {{16{imm[15]}}, imm};
    assign zeroImm = {16'h0000, imm};

    always_comb begin
        result      = '0;
        branchTaken = 1'b0;
        case (opcode)
            SPECIAL: begin
                case (funct)
                    ADDU: result = rsValue + rtValue;
                    SUBU: result = rsValue - rtValue;
                    AND:  result = rsValue & rtValue;
                    OR:   result = rsValue | rtValue;
                    XOR:  result = rsValue ^ rtValue;
                    SLT:  result = {31'd0, $signed(rsValue) < $signed(rtValue)};
                    SLTU: result = {31'd0, rsValue < rtValue};
                    SLL:  result = rtValue << shamt;
                    SRL:  result = rtValue >> shamt;
                    SRA:  result = $signed(rtValue) >>> shamt;
                    SLLV: result = rtValue << shiftVar;
                    SRLV: result = rtValue >> shiftVar;
                    SRAV: result = $signed(rtValue) >>> shiftVar;
                    JR, JALR: begin
                        // Register jumps are always taken
                        branchTaken = 1'b1;
                    end
                    default: begin
                        result = '0;
                    end
                endcase
            end
            ADDIU: begin
                result = rsValue + signImm;
            end
            SLTI: begin
                result = {31'd0, $signed(rsValue) < $signed(signImm)};
            end
            SLTIU: begin
                // Sign-extended immediate, unsigned compare
                result = {31'd0, rsValue < signImm};
            end
            ANDI: begin
                result = rsValue & zeroImm;
            end
            ORI: begin
                result = rsValue | zeroImm;
            end
            XORI: begin
                result = rsValue ^ zeroImm;
            end
            LUI: begin
                result = {imm, 16'h0000};
            end
            LW, SW: begin
                // Effective address
                result = rsValue + signImm;
            end
            BEQ: begin
                branchTaken = (rsValue == rtValue);
            end
            BNE: begin
                branchTaken = (rsValue != rtValue);
            end
            J, JAL: begin
                branchTaken = 1'b1;
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

//--- logic/registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [mipsPkg::regAddrWidth-1:0]   rsAddr,
    input  logic [mipsPkg::regAddrWidth-1:0]   rtAddr,
    input  logic                               writeEnable,
    input  logic [mipsPkg::regAddrWidth-1:0]   writeAddr,
    input  logic [mipsPkg::dataWidth-1:0]      writeValue,
    output logic [mipsPkg::dataWidth-1:0]      rsValue,
    output logic [mipsPkg::dataWidth-1:0]      rtValue,
    output logic [mipsPkg::dataWidth-1:0]      register_v0
);
    import mipsPkg::*;

    localparam int regCount = 1 << regAddrWidth;

    logic [dataWidth-1:0] regs [regCount];

    // Combinational read ports
    assign rsValue = regs[rsAddr];
    assign rtValue = regs[rtAddr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
            register_v0 <= '0;
        end else begin
            // Register zero stays hardwired to 0
            if (writeEnable && (writeAddr != '0)) begin
                regs[writeAddr] <= writeValue;
            end
            // v0 copy, valid once the core has halted
            register_v0 <= regs[2];
        end
    end

endmodule

//--- logic/mipsPkg.sv
package mipsPkg;

    // Datapath and bus width
    localparam int dataWidth = 32;

    // Register index width, 32 registers
    localparam int regAddrWidth = 5;

    // Boot ROM location of MIPS-I
    localparam logic [dataWidth-1:0] defaultResetVector = 32'hBFC0_0000;

    typedef enum logic [2:0] {
        FETCH     = 3'd0,
        DECODE    = 3'd1,
        EXECUTE   = 3'd2,
        MEMORY    = 3'd3,
        WRITEBACK = 3'd4,
        HALTED    = 3'd5
    } stateT;

    // Primary opcodes in bits 31:26
    typedef enum logic [5:0] {
        SPECIAL = 6'd0,
        J       = 6'd2,
        JAL     = 6'd3,
        BEQ     = 6'd4,
        BNE     = 6'd5,
        ADDIU   = 6'd9,
        SLTI    = 6'd10,
        SLTIU   = 6'd11,
        ANDI    = 6'd12,
        ORI     = 6'd13,
        XORI    = 6'd14,
        LUI     = 6'd15,
        LW      = 6'd35,
        SW      = 6'd43
    } opcodeT;

    // Function codes of SPECIAL, bits 5:0
    typedef enum logic [5:0] {
        SLL  = 6'd0,
        SRL  = 6'd2,
        SRA  = 6'd3,
        SLLV = 6'd4,
        SRLV = 6'd6,
        SRAV = 6'd7,
        JR   = 6'd8,
        JALR = 6'd9,
        ADDU = 6'd33,
        SUBU = 6'd35,
        AND  = 6'd36,
        OR   = 6'd37,
        XOR  = 6'd38,
        SLT  = 6'd42,
        SLTU = 6'd43
    } functT;

endpackage
